/* Makefile */
TOP := decodeTopTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): decodeTop.f $(wildcard design/*.sv tb/*.sv)
	verilator --binary --assert -j 0 --top-module $(TOP) -f decodeTop.f

lint:
	verilator --lint-only -Wall --top-module decodeTop \
		design/rvDecodePkg.sv design/instrFetch.sv design/instrQueue.sv \
		design/instrDecoder.sv design/decodeTop.sv

clean:
	rm -rf obj_dir

/* decodeTop.f */
design/rvDecodePkg.sv
design/instrFetch.sv
design/instrQueue.sv
design/instrDecoder.sv
design/decodeTop.sv
tb/decodeTopTb.sv

/* design/decodeTop.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeTop (
    input logic clk,
    input logic rstN,
    input logic loadEn,
    input logic [rvDecodePkg::pcWidth-1:0] loadAddr,
    input rvDecodePkg::instrWord loadWord,
    input logic start,
    input logic [rvDecodePkg::pcWidth:0] progLen,
    output logic decValid,
    output rvDecodePkg::decodedInstr decOut,
    output logic busy
);
    import rvDecodePkg::*;

    logic pushEn;
    fetchEntry pushEntry;
    logic full;
    logic empty;
    logic popEn;
    fetchEntry headEntry;
    logic fetchDone;

    instrFetch fetch_i (
        .clk(clk),
        .rstN(rstN),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadWord(loadWord),
        .start(start),
        .progLen(progLen),
        .full(full),
        .pushEn(pushEn),
        .pushEntry(pushEntry),
        .fetchDone(fetchDone)
    );

    instrQueue queue_i (
        .clk(clk),
        .rstN(rstN),
        .pushEn(pushEn),
        .pushEntry(pushEntry),
        .popEn(popEn),
        .headEntry(headEntry),
        .full(full),
        .empty(empty)
    );

    instrDecoder decoder_i (
        .clk(clk),
        .rstN(rstN),
        .empty(empty),
        .headEntry(headEntry),
        .fetchDone(fetchDone),
        .popEn(popEn),
        .decValid(decValid),
        .decOut(decOut),
        .busy(busy)
    );

endmodule

`default_nettype wire

/* design/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input logic clk,
    input logic rstN,
    input logic empty,
    input rvDecodePkg::fetchEntry headEntry,
    input logic fetchDone,
    output logic popEn,
    output logic decValid,
    output rvDecodePkg::decodedInstr decOut,
    output logic busy
);
    import rvDecodePkg::*;

    instrWord word;
    logic [xlen-1:0] iImm;
    logic [xlen-1:0] sImm;
    logic [xlen-1:0] bImm;
    logic [xlen-1:0] uImm;
    logic [xlen-1:0] jImm;
    logic [xlen-1:0] shamtImm;
    logic isShift;
    logic legal;
    aluOp op;
    decodedInstr rec;

    // aluNone marks a bad funct pair
    function automatic aluOp regAluOp(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input logic wordForm);
        aluOp res;
        res = aluNone;
        case (funct7)
            7'b0000000: begin
                case (funct3)
                    3'b000: res = aluAdd;
                    3'b001: res = aluSll;
                    3'b010: res = wordForm ? aluNone : aluSlt;
                    3'b011: res = wordForm ? aluNone : aluSltu;
                    3'b100: res = wordForm ? aluNone : aluXor;
                    3'b101: res = aluSrl;
                    3'b110: res = wordForm ? aluNone : aluOr;
                    default: res = wordForm ? aluNone : aluAnd;
                endcase
            end
            7'b0100000: begin
                if (funct3 == 3'b000) begin
                    res = aluSub;
                end else if (funct3 == 3'b101) begin
                    res = aluSra;
                end
            end
            7'b0000001: begin
                case (funct3)
                    3'b000: res = aluMul;
                    3'b001: res = wordForm ? aluNone : aluMulh;
                    3'b010: res = wordForm ? aluNone : aluMulhsu;
                    3'b011: res = wordForm ? aluNone : aluMulhu;
                    3'b100: res = aluDiv;
                    3'b101: res = aluDivu;
                    3'b110: res = aluRem;
                    default: res = aluRemu;
                endcase
            end
            default: res = aluNone;
        endcase
        return res;
    endfunction

    // word-form shifts also need bit 25 clear
    function automatic aluOp immAluOp(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input logic wordForm);
        aluOp res;
        logic shiftOk;
        res = aluNone;
        shiftOk = !wordForm || !funct7[0];
        case (funct3)
            3'b000: res = aluAdd;
            3'b010: res = wordForm ? aluNone : aluSlt;
            3'b011: res = wordForm ? aluNone : aluSltu;
            3'b100: res = wordForm ? aluNone : aluXor;
            3'b110: res = wordForm ? aluNone : aluOr;
            3'b111: res = wordForm ? aluNone : aluAnd;
            3'b001: begin
                if (funct7[6:1] == 6'b000000 && shiftOk) begin
                    res = aluSll;
                end
            end
            default: begin
                if (funct7[6:1] == 6'b000000 && shiftOk) begin
                    res = aluSrl;
                end else if (funct7[6:1] == 6'b010000 && shiftOk) begin
                    res = aluSra;
                end
            end
        endcase
        return res;
    endfunction

    assign popEn = !empty;
    assign word = headEntry.word;

    assign iImm = {{(xlen - 12){word.i.imm[11]}}, word.i.imm};
    assign sImm = {{(xlen - 12){word.s.immHi[6]}}, word.s.immHi, word.s.immLo};
    assign bImm = {{(xlen - 13){word.b.imm12}}, word.b.imm12, word.b.imm11,
                   word.b.imm10to5, word.b.imm4to1, 1'b0};
    assign uImm = {{(xlen - 32){word.u.imm[19]}}, word.u.imm, 12'b0};
    assign jImm = {{(xlen - 21){word.j.imm20}}, word.j.imm20, word.j.imm19to12,
                   word.j.imm11, word.j.imm10to1, 1'b0};
    assign isShift = (word.i.funct3 == 3'b001) || (word.i.funct3 == 3'b101);
    // 6-bit shift amount for normal forms, 5-bit for word forms
    assign shamtImm = (word.r.opcode == opOpImm32) ? {{(xlen - 5){1'b0}}, word.raw[24:20]}
                                                   : {{(xlen - 6){1'b0}}, word.raw[25:20]};

    always_comb begin
        rec = '0;
        rec.pc = headEntry.pc;
        rec.funct3 = word.r.funct3;
        rec.rd = word.r.rd;
        rec.rs1 = word.r.rs1;
        rec.rs2 = word.r.rs2;
        op = aluNone;
        legal = 1'b1;
        case (word.r.opcode)
            opOp, opOp32: begin
                rec.cls = clsAluReg;
                rec.isWord = (word.r.opcode == opOp32);
                op = regAluOp(word.r.funct7, word.r.funct3, rec.isWord);
                legal = (op != aluNone);
                rec.usesRs1 = 1'b1;
                rec.usesRs2 = 1'b1;
                rec.writesRd = 1'b1;
            end
            opOpImm, opOpImm32: begin
                rec.cls = clsAluImm;
                rec.isWord = (word.r.opcode == opOpImm32);
                op = immAluOp(word.r.funct7, word.r.funct3, rec.isWord);
                legal = (op != aluNone);
                rec.usesRs1 = 1'b1;
                rec.writesRd = 1'b1;
                rec.imm = isShift ? shamtImm : iImm;
            end
            opLoad: begin
                rec.cls = clsLoad;
                op = aluAdd;
                legal = (word.i.funct3 != 3'b111);
                rec.usesRs1 = 1'b1;
                rec.writesRd = 1'b1;
                rec.imm = iImm;
            end
            opStore: begin
                rec.cls = clsStore;
                op = aluAdd;
                legal = !word.s.funct3[2];
                rec.usesRs1 = 1'b1;
                rec.usesRs2 = 1'b1;
                rec.imm = sImm;
            end
            opBranch: begin
                // compare type stays in funct3
                rec.cls = clsBranch;
                legal = (word.b.funct3[2:1] != 2'b01);
                rec.usesRs1 = 1'b1;
                rec.usesRs2 = 1'b1;
                rec.imm = bImm;
            end
            opJal: begin
                rec.cls = clsJal;
                rec.writesRd = 1'b1;
                rec.imm = jImm;
            end
            opJalr: begin
                rec.cls = clsJalr;
                op = aluAdd;
                legal = (word.i.funct3 == 3'b000);
                rec.usesRs1 = 1'b1;
                rec.writesRd = 1'b1;
                rec.imm = iImm;
            end
            opLui: begin
                rec.cls = clsLui;
                rec.writesRd = 1'b1;
                rec.imm = uImm;
            end
            opAuipc: begin
                rec.cls = clsAuipc;
                op = aluAdd;
                rec.writesRd = 1'b1;
                rec.imm = uImm;
            end
            default: legal = 1'b0;
        endcase
        if (legal) begin
            rec.op = op;
        end else begin
            rec.cls = clsIllegal;
            rec.op = aluNone;
            rec.isWord = 1'b0;
            rec.usesRs1 = 1'b0;
            rec.usesRs2 = 1'b0;
            rec.writesRd = 1'b0;
            rec.imm = '0;
            rec.illegal = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (popEn) begin
            decOut <= rec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
            busy <= 1'b0;
        end else begin
            decValid <= popEn;
            // stays up through the cycle of the last record
            busy <= !(fetchDone && empty && !popEn);
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        decValid && decOut.illegal |-> !decOut.writesRd && !decOut.usesRs1 && !decOut.usesRs2);

endmodule

`default_nettype wire

/* design/instrFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instrFetch (
    input logic clk,
    input logic rstN,
    input logic loadEn,
    input logic [rvDecodePkg::pcWidth-1:0] loadAddr,
    input rvDecodePkg::instrWord loadWord,
    input logic start,
    input logic [rvDecodePkg::pcWidth:0] progLen,
    input logic full,
    output logic pushEn,
    output rvDecodePkg::fetchEntry pushEntry,
    output logic fetchDone
);
    import rvDecodePkg::*;

    localparam logic [pcWidth:0] one = (pcWidth + 1)'(1);

    instrWord progMem [progDepth];
    logic [pcWidth:0] lenQ;
    logic [pcWidth:0] issueCnt;
    logic [pcWidth:0] pushCnt;
    logic running;
    logic rdValid;
    fetchEntry rdEntry;
    logic advance;
    logic issue;

    // read slot frees when it is empty or being pushed this cycle
    assign advance = !rdValid || !full;
    assign issue = running && advance;
    assign pushEn = rdValid && !full;
    assign pushEntry = rdEntry;

    always_ff @(posedge clk) begin
        if (loadEn) begin
            progMem[loadAddr] <= loadWord;
        end
    end

    // registered read that doubles as the pending word while full
    always_ff @(posedge clk) begin
        if (issue) begin
            rdEntry.pc <= issueCnt[pcWidth-1:0];
            rdEntry.word <= progMem[issueCnt[pcWidth-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            running <= 1'b0;
            rdValid <= 1'b0;
            issueCnt <= '0;
            pushCnt <= '0;
            lenQ <= '0;
            fetchDone <= 1'b1;
        end else if (start) begin
            running <= 1'b1;
            rdValid <= 1'b0;
            issueCnt <= '0;
            pushCnt <= '0;
            lenQ <= progLen;
            fetchDone <= 1'b0;
        end else begin
            if (advance) begin
                rdValid <= issue;
            end
            if (issue) begin
                issueCnt <= issueCnt + one;
                if (issueCnt == lenQ - one) begin
                    running <= 1'b0;
                end
            end
            if (pushEn) begin
                pushCnt <= pushCnt + one;
                if (pushCnt == lenQ - one) begin
                    fetchDone <= 1'b1;
                end
            end
        end
    end

    // never more than progLen pushes per start
    assert property (@(posedge clk) disable iff (!rstN) pushEn |-> !fetchDone);

endmodule

`default_nettype wire

/* design/instrQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module instrQueue (
    input logic clk,
    input logic rstN,
    input logic pushEn,
    input rvDecodePkg::fetchEntry pushEntry,
    input logic popEn,
    output rvDecodePkg::fetchEntry headEntry,
    output logic full,
    output logic empty
);
    import rvDecodePkg::*;

    localparam int ptrWidth = $clog2(queueDepth);
    localparam logic [ptrWidth-1:0] ptrOne = ptrWidth'(1);
    localparam logic [queueCountWidth-1:0] countFull = queueCountWidth'(queueDepth);

    fetchEntry entries [queueDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [queueCountWidth-1:0] count;
    logic [queueCountWidth-1:0] countNext;
    logic almostFull;

    // first-word fall-through
    assign headEntry = entries[rdPtr];

    assign countNext = count + queueCountWidth'(pushEn) - queueCountWidth'(popEn);
    assign almostFull = (count == countFull - queueCountWidth'(1));

    always_ff @(posedge clk) begin
        if (pushEn) begin
            entries[wrPtr] <= pushEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end else begin
            if (pushEn) begin
                wrPtr <= wrPtr + ptrOne;
            end
            if (popEn) begin
                rdPtr <= rdPtr + ptrOne;
            end
            count <= countNext;
            // flags come from the next count so they hold at the start of a cycle
            full <= (full && !popEn) || (almostFull && pushEn && !popEn);
            empty <= (countNext == '0);
        end
    end

    // fetch must honor full
    assert property (@(posedge clk) disable iff (!rstN) pushEn |-> !full);

    // decoder must honor empty
    assert property (@(posedge clk) disable iff (!rstN) popEn |-> !empty);

    // flag register agrees with the occupancy count
    assert property (@(posedge clk) disable iff (!rstN) full == (count == countFull));

endmodule

`default_nettype wire

/* design/rvDecodePkg.sv */
`default_nettype none

package rvDecodePkg;

    localparam int xlen = 64;
    localparam int progDepth = 32;
    localparam int pcWidth = 5;
    localparam int queueDepth = 4;
    localparam int queueCountWidth = 3;

    // base opcodes recognized by the decoder
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opAuipc = 7'b0010111;
    localparam logic [6:0] opOpImm32 = 7'b0011011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opOp = 7'b0110011;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opOp32 = 7'b0111011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam logic [6:0] opJal = 7'b1101111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFormat;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } iFormat;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFormat;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic imm11;
        logic [6:0] opcode;
    } bFormat;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0] rd;
        logic [6:0] opcode;
    } uFormat;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10to1;
        logic imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFormat;

    // one instruction word, seen through each encoding format
    typedef union packed {
        logic [31:0] raw;
        rFormat r;
        iFormat i;
        sFormat s;
        bFormat b;
        uFormat u;
        jFormat j;
    } instrWord;

    typedef enum logic [3:0] {
        clsAluReg, clsAluImm, clsLoad, clsStore, clsBranch,
        clsJal, clsJalr, clsLui, clsAuipc, clsIllegal
    } instrClass;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluSra, aluOr, aluAnd,
        aluMul, aluMulh, aluMulhsu, aluMulhu, aluDiv, aluDivu, aluRem, aluRemu, aluNone
    } aluOp;

    typedef struct packed {
        logic [pcWidth-1:0] pc;
        instrWord word;
    } fetchEntry;

    typedef struct packed {
        logic [pcWidth-1:0] pc;
        instrClass cls;
        aluOp op;
        logic isWord;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic usesRs1;
        logic usesRs2;
        logic writesRd;
        logic [xlen-1:0] imm;
        logic illegal;
    } decodedInstr;

endpackage

`default_nettype wire

/* tb/decodeTopTb.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeTopTb;
    import rvDecodePkg::*;

    localparam int resetCycles = 10;
    localparam int numPrograms = 6;
    localparam int timeoutCycles = 200 * numPrograms + resetCycles;

    // one of each class, several with negative immediates
    localparam logic [31:0] directedProg [14] = '{
        32'h002081B3,  // add x3, x1, x2
        32'h407302B3,  // sub x5, x6, x7
        32'h02A4A433,  // mulhsu x8, x9, x10
        32'h40D655BB,  // sraw x11, x12, x13
        32'h43F7D713,  // srai x14, x15, 63
        32'h01F8D81B,  // srliw x16, x17, 31
        32'hFF813903,  // ld x18, -8(x2)
        32'hFF313823,  // sd x19, -16(x2)
        32'hFF5A70E3,  // bgeu x20, x21, -32
        32'h801FF0EF,  // jal x1, -2048
        32'h00008067,  // jalr x0, 0(x1)
        32'hFFFFF2B7,  // lui x5, 0xfffff
        32'h12345317,  // auipc x6, 0x12345
        32'hFFF00393   // addi x7, x0, -1
    };

    localparam logic [31:0] illegalProg [4] = '{
        32'h00A5807F,  // unknown opcode
        32'h202081B3,  // opOp with funct7 0x10
        32'h0020B063,  // branch funct3 011
        32'h00000073   // ecall, system is not decoded
    };

    // legal opcodes plus system, fence and an unused one
    localparam logic [6:0] opTable [14] = '{
        opLoad, opOpImm, opAuipc, opOpImm32, opStore, opOp, opLui,
        opOp32, opBranch, opJalr, opJal, 7'b1110011, 7'b0001111, 7'b1111111
    };

    logic clk = 1'b0;
    logic rstN;
    logic loadEn;
    logic [pcWidth-1:0] loadAddr;
    instrWord loadWord;
    logic start;
    logic [pcWidth:0] progLen;
    logic decValid;
    decodedInstr decOut;
    logic busy;

    logic [31:0] mirror [progDepth];
    decodedInstr expQ [$];
    logic [31:0] lfsrState;
    logic expectIllegal;
    int cycleCount;

    decodeTop dut_i (
        .clk(clk),
        .rstN(rstN),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadWord(loadWord),
        .start(start),
        .progLen(progLen),
        .decValid(decValid),
        .decOut(decOut),
        .busy(busy)
    );

    always #20 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [6:0] opc;
        logic [6:0] f7;
        logic [1:0] sel;
        logic [17:0] mid;
        opc = opTable[4'(takeBits(4) % 14)];
        sel = 2'(takeBits(2));
        case (sel)
            2'd0: f7 = 7'h00;
            2'd1: f7 = 7'h20;
            2'd2: f7 = 7'h01;
            default: f7 = 7'(takeBits(7));
        endcase
        // rs2, rs1, funct3 and rd in one draw
        mid = 18'(takeBits(18));
        return {f7, mid, opc};
    endfunction

    function automatic logic [63:0] sext(input logic [31:0] v, input int bits);
        logic [63:0] mask;
        mask = (64'd1 << bits) - 64'd1;
        return v[bits-1] ? ({32'd0, v} | ~mask) : ({32'd0, v} & mask);
    endfunction

    function automatic aluOp baseOp(input logic [2:0] f3);
        case (f3)
            3'd0: return aluAdd;
            3'd1: return aluSll;
            3'd2: return aluSlt;
            3'd3: return aluSltu;
            3'd4: return aluXor;
            3'd5: return aluSrl;
            3'd6: return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic decodedInstr refDecode(input logic [31:0] w, input logic [4:0] pc);
        decodedInstr d;
        logic [6:0] f7;
        logic [2:0] f3;
        logic wordForm;
        logic ok;
        d = '0;
        f7 = w[31:25];
        f3 = w[14:12];
        wordForm = (w[6:0] == opOp32) || (w[6:0] == opOpImm32);
        ok = 1'b1;
        d.pc = pc;
        d.funct3 = f3;
        d.rd = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.op = aluAdd;
        case (w[6:0])
            opOp, opOp32: begin
                d.cls = clsAluReg;
                d.isWord = wordForm;
                d.usesRs1 = 1'b1;
                d.usesRs2 = 1'b1;
                d.writesRd = 1'b1;
                if (f7 == 7'h00 && (!wordForm || f3 inside {3'd0, 3'd1, 3'd5})) begin
                    d.op = baseOp(f3);
                end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
                    d.op = (f3 == 3'd0) ? aluSub : aluSra;
                end else if (f7 == 7'h01 && (!wordForm || !(f3 inside {3'd1, 3'd2, 3'd3}))) begin
                    d.op = aluOp'(5'd10 + 5'(f3));
                end else begin
                    ok = 1'b0;
                end
            end
            opOpImm, opOpImm32: begin
                d.cls = clsAluImm;
                d.isWord = wordForm;
                d.usesRs1 = 1'b1;
                d.writesRd = 1'b1;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    // W shifts take a 5-bit shamt and need bit 25 clear
                    ok = (w[31:26] == 6'd0 || (f3 == 3'd5 && w[31:26] == 6'b010000))
                         && !(wordForm && w[25]);
                    d.op = (f3 == 3'd1) ? aluSll : (w[30] ? aluSra : aluSrl);
                    d.imm = wordForm ? 64'(w[24:20]) : 64'(w[25:20]);
                end else if (!wordForm || f3 == 3'd0) begin
                    d.op = baseOp(f3);
                    d.imm = sext(32'(w[31:20]), 12);
                end else begin
                    ok = 1'b0;
                end
            end
            opLoad: begin
                d.cls = clsLoad;
                ok = (f3 != 3'd7);
                d.usesRs1 = 1'b1;
                d.writesRd = 1'b1;
                d.imm = sext(32'(w[31:20]), 12);
            end
            opStore: begin
                d.cls = clsStore;
                ok = !f3[2];
                d.usesRs1 = 1'b1;
                d.usesRs2 = 1'b1;
                d.imm = sext(32'({w[31:25], w[11:7]}), 12);
            end
            opBranch: begin
                d.cls = clsBranch;
                d.op = aluNone;
                ok = !(f3 == 3'd2 || f3 == 3'd3);
                d.usesRs1 = 1'b1;
                d.usesRs2 = 1'b1;
                d.imm = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            end
            opJal: begin
                d.cls = clsJal;
                d.op = aluNone;
                d.writesRd = 1'b1;
                d.imm = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
            end
            opJalr: begin
                d.cls = clsJalr;
                ok = (f3 == 3'd0);
                d.usesRs1 = 1'b1;
                d.writesRd = 1'b1;
                d.imm = sext(32'(w[31:20]), 12);
            end
            opLui, opAuipc: begin
                d.cls = (w[6:0] == opLui) ? clsLui : clsAuipc;
                d.op = (w[6:0] == opLui) ? aluNone : aluAdd;
                d.writesRd = 1'b1;
                d.imm = sext({w[31:12], 12'b0}, 32);
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            d.cls = clsIllegal;
            d.op = aluNone;
            d.isWord = 1'b0;
            d.usesRs1 = 1'b0;
            d.usesRs2 = 1'b0;
            d.writesRd = 1'b0;
            d.imm = '0;
            d.illegal = 1'b1;
        end
        return d;
    endfunction

    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t: %s mismatch, got %h expected %h", $time, name, got, want);
            $display("Testbench failed");
            $fatal(1, "field mismatch");
        end
    endtask

    task automatic loadProgram(input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            loadEn <= 1'b1;
            loadAddr <= 5'(i);
            loadWord.raw <= mirror[5'(i)];
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    task automatic runProgram(input int len);
        for (int i = 0; i < len; i++) begin
            expQ.push_back(refDecode(mirror[5'(i)], 5'(i)));
        end
        @(posedge clk);
        start <= 1'b1;
        progLen <= 6'(len);
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!busy) begin
            @(negedge clk);
        end
        while (busy) begin
            @(negedge clk);
        end
        if (expQ.size() != 0) begin
            $display("busy fell with %0d records still missing", expQ.size());
            $display("Testbench failed");
            $fatal(1, "too few records");
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("run did not finish within %0d cycles", timeoutCycles);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        decodedInstr want;
        if (rstN && decValid) begin
            if (!busy) begin
                $display("a record came out while busy was low");
                $display("Testbench failed");
                $fatal(1, "record outside busy");
            end else if (expQ.size() == 0) begin
                $display("more records came out than were started");
                $display("Testbench failed");
                $fatal(1, "extra record");
            end else begin
                want = expQ.pop_front();
                checkEq("pc", 64'(decOut.pc), 64'(want.pc));
                checkEq("cls", 64'(decOut.cls), 64'(want.cls));
                checkEq("op", 64'(decOut.op), 64'(want.op));
                checkEq("isWord", 64'(decOut.isWord), 64'(want.isWord));
                checkEq("funct3", 64'(decOut.funct3), 64'(want.funct3));
                checkEq("rd", 64'(decOut.rd), 64'(want.rd));
                checkEq("rs1", 64'(decOut.rs1), 64'(want.rs1));
                checkEq("rs2", 64'(decOut.rs2), 64'(want.rs2));
                checkEq("usesRs1", 64'(decOut.usesRs1), 64'(want.usesRs1));
                checkEq("usesRs2", 64'(decOut.usesRs2), 64'(want.usesRs2));
                checkEq("writesRd", 64'(decOut.writesRd), 64'(want.writesRd));
                checkEq("imm", decOut.imm, want.imm);
                checkEq("illegal", 64'(decOut.illegal), 64'(want.illegal));
                if (expectIllegal) begin
                    checkEq("illegalShape", 64'({decOut.cls == clsIllegal, decOut.illegal,
                        decOut.writesRd, decOut.usesRs1, decOut.usesRs2}), 64'(5'b11000));
                end
            end
        end
    end

    initial begin
        rstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadWord = '0;
        start = 1'b0;
        progLen = '0;
        expectIllegal = 1'b0;
        cycleCount = 0;
        lfsrState = 32'd70717;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        for (int i = 0; i < 14; i++) begin
            mirror[5'(i)] = directedProg[i];
        end
        loadProgram(14);
        runProgram(14);

        for (int i = 0; i < 4; i++) begin
            mirror[5'(i)] = illegalProg[i];
        end
        loadProgram(4);
        expectIllegal = 1'b1;
        runProgram(4);
        expectIllegal = 1'b0;

        for (int i = 0; i < progDepth; i++) begin
            mirror[5'(i)] = randomWord();
        end
        loadProgram(progDepth);
        runProgram(progDepth);

        // back to back starts
        runProgram(1);
        runProgram(7);

        // rewritten words must replace the stale ones
        for (int i = 0; i < 4; i++) begin
            mirror[5'(i)] = mirror[5'(i)] ^ 32'hFFFF_F000;
        end
        loadProgram(4);
        runProgram(4);

        repeat (4) @(posedge clk);
        if (expQ.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("%0d expected records never arrived", expQ.size());
            $display("Testbench failed");
            $fatal(1, "missing records");
        end
    end

endmodule

`default_nettype wire
